//--- Makefile
TOP := video_capture_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module video_capture_top

clean:
	rm -rf obj_dir sim.log

//--- hw/color_conv.sv
`timescale 1ns/100ps

module color_conv (
    input  logic                                clock,
    input  logic                                nreset,
    input  video_pkg::color_mode_t              color_mode,
    input  logic                                in_wren,
    input  logic [video_pkg::ADDR_WIDTH-1:0]    in_wraddr,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0] in_red,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0] in_green,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0] in_blue,
    input  logic                                in_starttrigger,
    output logic                                wren,
    output logic [video_pkg::ADDR_WIDTH-1:0]    wraddr,
    output logic [video_pkg::PIXEL_WIDTH-1:0]   wrdata,
    output logic                                starttrigger
);
    localparam int CHW = video_pkg::CHANNEL_WIDTH;

    logic [CHW+1:0]                      grey_sum;
    logic [CHW-1:0]                      grey;
    logic [video_pkg::PIXEL_WIDTH-1:0]   converted;

    // R + 2G + B, then drop two bits
    assign grey_sum = {2'b00, in_red} + {1'b0, in_green, 1'b0} + {2'b00, in_blue};
    assign grey     = grey_sum[CHW+1:2];

    always_comb begin
        case (color_mode)
            video_pkg::COLOR_RGB:    converted = {in_red, in_green, in_blue};
            video_pkg::COLOR_BGR:    converted = {in_blue, in_green, in_red};
            video_pkg::COLOR_GREY:   converted = {grey, grey, grey};
            video_pkg::COLOR_INVERT: converted = ~{in_red, in_green, in_blue};
            default:                 converted = {in_red, in_green, in_blue};
        endcase
    end

    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            wren         <= 1'b0;
            starttrigger <= 1'b0;
        end else begin
            wren         <= in_wren;
            starttrigger <= in_starttrigger;
        end
    end

    always_ff @(posedge clock) begin
        if (in_wren) begin
            wraddr <= in_wraddr;
            wrdata <= converted;
        end
    end

endmodule

//--- hw/frame_buffer_ram.sv
`timescale 1ns/100ps

module frame_buffer_ram #(
    parameter int RAM_WORDS = 512
) (
    input  logic                              clock,
    input  logic                              wren,
    input  logic [video_pkg::ADDR_WIDTH-1:0]  wraddr,
    input  logic [video_pkg::PIXEL_WIDTH-1:0] wrdata,
    input  logic [video_pkg::ADDR_WIDTH-1:0]  rd_addr,
    output logic [video_pkg::PIXEL_WIDTH-1:0] rd_data
);
    localparam int WORD_BITS = $clog2(RAM_WORDS);

    logic [video_pkg::PIXEL_WIDTH-1:0] mem [RAM_WORDS];

    logic [WORD_BITS-1:0] wr_index;
    logic [WORD_BITS-1:0] rd_index;

    assign wr_index = wraddr[WORD_BITS-1:0];
    assign rd_index = rd_addr[WORD_BITS-1:0];

    // Write port
    always_ff @(posedge clock) begin
        if (wren) begin
            mem[wr_index] <= wrdata;
        end
    end

    // Registered read, old data on a same cycle write
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_index];
    end

endmodule

//--- hw/gamma_conv.sv
`timescale 1ns/100ps

module gamma_conv (
    input  logic                                clock,
    input  logic                                nreset,
    input  video_pkg::gamma_mode_t              gamma_mode,
    input  logic                                in_wren,
    input  logic [video_pkg::ADDR_WIDTH-1:0]    in_wraddr,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0] in_red,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0] in_green,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0] in_blue,
    input  logic                                in_starttrigger,
    output logic                                wren,
    output logic [video_pkg::ADDR_WIDTH-1:0]    wraddr,
    output logic [video_pkg::PIXEL_WIDTH-1:0]   wrdata,
    output logic                                starttrigger
);
    localparam int CHW = video_pkg::CHANNEL_WIDTH;

    logic [video_pkg::PIXEL_WIDTH-1:0] in_pixel;
    logic [video_pkg::PIXEL_WIDTH-1:0] curved;

    assign in_pixel = {in_red, in_green, in_blue};

    // ====================
    // Per channel curve
    // ====================
    for (genvar ch = 0; ch < 3; ch++) begin : g_channel
        logic [CHW-1:0]   value;
        logic [CHW-1:0]   operand;
        logic [2*CHW-1:0] square;
        logic [CHW-1:0]   result;

        assign value = in_pixel[ch*CHW +: CHW];

        // Brighten squares the distance from full scale
        assign operand = (gamma_mode == video_pkg::GAMMA_BRIGHTEN) ? ~value : value;
        assign square  = operand * operand;

        always_comb begin
            case (gamma_mode)
                video_pkg::GAMMA_DARKEN:   result = square[2*CHW-1:CHW];
                video_pkg::GAMMA_BRIGHTEN: result = ~square[2*CHW-1:CHW]; // 255 - sq/256
                default:                   result = value;  // Linear and reserved
            endcase
        end

        assign curved[ch*CHW +: CHW] = result;
    end

    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            wren         <= 1'b0;
            starttrigger <= 1'b0;
        end else begin
            wren         <= in_wren;
            starttrigger <= in_starttrigger;
        end
    end

    always_ff @(posedge clock) begin
        if (in_wren) begin
            wraddr <= in_wraddr;
            wrdata <= curved;
        end
    end

endmodule

//--- hw/video2ram.sv
`timescale 1ns/100ps

module video2ram #(
    parameter int H_START      = 8,
    parameter int H_END        = 40,
    parameter int V_START_P    = 4,
    parameter int V_END_P      = 24,
    parameter int V_START_I    = 2,
    parameter int V_END_I      = 14,
    parameter int BUFFER_LINES = 4,
    parameter int TRIGGER_ADDR = 70,
    parameter int RAM_WORDS    = 512
) (
    input  logic                                 clock,
    input  logic                                 nreset,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0]  red,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0]  green,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0]  blue,
    input  logic [video_pkg::COUNTER_WIDTH-1:0]  counter_x,
    input  logic [video_pkg::COUNTER_WIDTH-1:0]  counter_y,
    input  logic                                 line_doubler,
    output logic                                 wren,
    output logic [video_pkg::ADDR_WIDTH-1:0]     wraddr,
    output logic [video_pkg::PIXEL_WIDTH-1:0]    wrdata,
    output logic                                 starttrigger
);
    localparam int CW          = video_pkg::COUNTER_WIDTH;
    localparam int AW          = video_pkg::ADDR_WIDTH;
    localparam int LINE_LENGTH = H_END - H_START;

    localparam logic [CW-1:0] H_START_C      = CW'(H_START);
    localparam logic [CW-1:0] H_END_C        = CW'(H_END);
    localparam logic [CW-1:0] V_START_P_C    = CW'(V_START_P);
    localparam logic [CW-1:0] V_END_P_C      = CW'(V_END_P);
    localparam logic [CW-1:0] V_START_I_C    = CW'(V_START_I);
    localparam logic [CW-1:0] V_END_I_C      = CW'(V_END_I);
    localparam logic [CW-1:0] BUFFER_LINES_C = CW'(BUFFER_LINES);
    localparam logic [AW-1:0] LINE_STEP      = AW'(LINE_LENGTH);
    localparam logic [AW-1:0] BASE_LIMIT     = AW'(RAM_WORDS - LINE_LENGTH);
    localparam logic [AW-1:0] TRIGGER_C      = AW'(TRIGGER_ADDR);

    logic          line_doubler_reg;
    logic [CW-1:0] v_start;
    logic [CW-1:0] v_end;
    logic [CW-1:0] x_offset;
    logic [CW-1:0] y_offset;
    logic [AW-1:0] line_base;
    logic [AW-1:0] capture_addr;
    logic          h_active;
    logic          v_active;
    logic          capture;
    logic          trigger_hit;

    // ====================
    // Window decode
    // ====================
    assign v_start = line_doubler_reg ? V_START_I_C : V_START_P_C;
    assign v_end   = line_doubler_reg ? V_END_I_C : V_END_P_C;

    assign h_active = (counter_x >= H_START_C) && (counter_x < H_END_C);
    assign v_active = (counter_y >= v_start) && (counter_y < v_end);
    assign capture  = h_active && v_active;

    assign x_offset     = counter_x - H_START_C;
    assign y_offset     = counter_y - v_start;
    assign capture_addr = line_base + x_offset[AW-1:0];

    // Only within the first lines of the active window
    assign trigger_hit = (y_offset < BUFFER_LINES_C) && (capture_addr == TRIGGER_C);

    // ====================
    // Control registers
    // ====================
    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            line_doubler_reg <= 1'b0;
            line_base        <= '0;
            wren             <= 1'b0;
            starttrigger     <= 1'b0;
        end else begin
            line_doubler_reg <= line_doubler;

            if (counter_x == H_END_C) begin    // Once per line
                if (v_active && line_base < BASE_LIMIT) begin
                    line_base <= line_base + LINE_STEP;
                end else begin
                    line_base <= '0;
                end
            end

            wren         <= capture;
            starttrigger <= capture && trigger_hit;
        end
    end

    // Pixel and address, held outside the window
    always_ff @(posedge clock) begin
        if (capture) begin
            wraddr <= capture_addr;
            wrdata <= {red, green, blue};
        end
    end

endmodule

//--- hw/video_capture_top.sv
`timescale 1ns/100ps

module video_capture_top #(
    parameter int H_START      = 8,
    parameter int H_END        = 40,
    parameter int V_START_P    = 4,
    parameter int V_END_P      = 24,
    parameter int V_START_I    = 2,
    parameter int V_END_I      = 14,
    parameter int BUFFER_LINES = 4,
    parameter int TRIGGER_ADDR = 70,
    parameter int RAM_WORDS    = 512
) (
    input  logic                                clock,
    input  logic                                nreset,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0] red,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0] green,
    input  logic [video_pkg::CHANNEL_WIDTH-1:0] blue,
    input  logic [video_pkg::COUNTER_WIDTH-1:0] counter_x,
    input  logic [video_pkg::COUNTER_WIDTH-1:0] counter_y,
    input  logic                                line_doubler,
    input  video_pkg::color_mode_t              color_mode,
    input  video_pkg::gamma_mode_t              gamma_mode,
    output logic                                wren,
    output logic [video_pkg::ADDR_WIDTH-1:0]    wraddr,
    output logic [video_pkg::PIXEL_WIDTH-1:0]   wrdata,
    output logic                                starttrigger,
    input  logic [video_pkg::ADDR_WIDTH-1:0]    rd_addr,
    output logic [video_pkg::PIXEL_WIDTH-1:0]   rd_data
);
    localparam int CHW = video_pkg::CHANNEL_WIDTH;

    // Capture stage outputs
    logic                               cap_wren;
    logic [video_pkg::ADDR_WIDTH-1:0]   cap_wraddr;
    logic [video_pkg::PIXEL_WIDTH-1:0]  cap_wrdata;
    logic                               cap_trigger;

    // Colour stage outputs
    logic                               cc_wren;
    logic [video_pkg::ADDR_WIDTH-1:0]   cc_wraddr;
    logic [video_pkg::PIXEL_WIDTH-1:0]  cc_wrdata;
    logic                               cc_trigger;

    video2ram #(
        .H_START      (H_START),
        .H_END        (H_END),
        .V_START_P    (V_START_P),
        .V_END_P      (V_END_P),
        .V_START_I    (V_START_I),
        .V_END_I      (V_END_I),
        .BUFFER_LINES (BUFFER_LINES),
        .TRIGGER_ADDR (TRIGGER_ADDR),
        .RAM_WORDS    (RAM_WORDS)
    ) u_video2ram (
        .clock        (clock),
        .nreset       (nreset),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .counter_x    (counter_x),
        .counter_y    (counter_y),
        .line_doubler (line_doubler),
        .wren         (cap_wren),
        .wraddr       (cap_wraddr),
        .wrdata       (cap_wrdata),
        .starttrigger (cap_trigger)
    );

    color_conv u_color_conv (
        .clock           (clock),
        .nreset          (nreset),
        .color_mode      (color_mode),
        .in_wren         (cap_wren),
        .in_wraddr       (cap_wraddr),
        .in_red          (cap_wrdata[3*CHW-1:2*CHW]),
        .in_green        (cap_wrdata[2*CHW-1:CHW]),
        .in_blue         (cap_wrdata[CHW-1:0]),
        .in_starttrigger (cap_trigger),
        .wren            (cc_wren),
        .wraddr          (cc_wraddr),
        .wrdata          (cc_wrdata),
        .starttrigger    (cc_trigger)
    );

    gamma_conv u_gamma_conv (
        .clock           (clock),
        .nreset          (nreset),
        .gamma_mode      (gamma_mode),
        .in_wren         (cc_wren),
        .in_wraddr       (cc_wraddr),
        .in_red          (cc_wrdata[3*CHW-1:2*CHW]),
        .in_green        (cc_wrdata[2*CHW-1:CHW]),
        .in_blue         (cc_wrdata[CHW-1:0]),
        .in_starttrigger (cc_trigger),
        .wren            (wren),
        .wraddr          (wraddr),
        .wrdata          (wrdata),
        .starttrigger    (starttrigger)
    );

    frame_buffer_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_frame_buffer_ram (
        .clock   (clock),
        .wren    (wren),
        .wraddr  (wraddr),
        .wrdata  (wrdata),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- hw/video_pkg.sv
package video_pkg;

    // ====================
    // Shared widths
    // ====================
    localparam int ADDR_WIDTH    = 10;     // Frame buffer address
    localparam int COUNTER_WIDTH = 12;     // Timing generator counters
    localparam int CHANNEL_WIDTH = 8;
    localparam int PIXEL_WIDTH   = 3 * CHANNEL_WIDTH;

    // ====================
    // Mode encodings
    // ====================
    typedef enum logic [1:0] {
        COLOR_RGB    = 2'd0,   // Unchanged
        COLOR_BGR    = 2'd1,   // Red and blue swapped
        COLOR_GREY   = 2'd2,   // (R + 2G + B) / 4 on all channels
        COLOR_INVERT = 2'd3    // 255 - x
    } color_mode_t;

    typedef enum logic [1:0] {
        GAMMA_LINEAR   = 2'd0,
        GAMMA_DARKEN   = 2'd1, // x*x / 256
        GAMMA_BRIGHTEN = 2'd2, // 255 - (255-x)^2 / 256
        GAMMA_RESERVED = 2'd3  // Same as linear
    } gamma_mode_t;

endpackage

//--- sim/video_capture_checker.sv
`timescale 1ns/100ps

module video_capture_checker #(
    parameter int H_START   = 8,
    parameter int H_END     = 40,
    parameter int V_START_P = 4,
    parameter int V_END_P   = 24,
    parameter int V_START_I = 2,
    parameter int V_END_I   = 14,
    parameter int RAM_WORDS = 512
) (
    input logic                                clock,
    input logic                                nreset,
    input logic [video_pkg::COUNTER_WIDTH-1:0] counter_x,
    input logic [video_pkg::COUNTER_WIDTH-1:0] counter_y,
    input logic                                line_doubler,
    input logic                                wren,
    input logic [video_pkg::ADDR_WIDTH-1:0]    wraddr,
    input logic                                starttrigger
);
    logic       ld_q;
    logic       v_window;
    logic       in_window;
    logic [2:0] window_pipe;    // Window flag, aligned with the 3 stage pipeline
    logic       capture_seen;
    int         assert_failures = 0;

    assign v_window = ld_q ?
        (int'(counter_y) >= V_START_I && int'(counter_y) < V_END_I) :
        (int'(counter_y) >= V_START_P && int'(counter_y) < V_END_P);
    assign in_window = v_window && int'(counter_x) >= H_START && int'(counter_x) < H_END;

    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            ld_q         <= 1'b0;
            window_pipe  <= '0;
            capture_seen <= 1'b0;
        end else begin
            ld_q        <= line_doubler;
            window_pipe <= {window_pipe[1:0], in_window};
            if (window_pipe[2]) begin
                capture_seen <= 1'b1;
            end
        end
    end

    // ====================
    // Write stream rules
    // ====================
    // Also holds while reset is applied
    assert property (@(posedge clock)
        !(capture_seen || window_pipe[2]) |-> !wren && !starttrigger)
        else begin $error("wren raised before the first captured pixel"); assert_failures++; end

    assert property (@(posedge clock) disable iff (!nreset) starttrigger |-> wren)
        else begin $error("starttrigger without wren"); assert_failures++; end

    assert property (@(posedge clock) disable iff (!nreset) wren |-> int'(wraddr) < RAM_WORDS)
        else begin $error("wraddr beyond the frame buffer"); assert_failures++; end

    assert property (@(posedge clock) disable iff (!nreset) !window_pipe[2] |-> !wren)
        else begin $error("write for a pixel outside the window"); assert_failures++; end

endmodule

bind video_capture_top video_capture_checker #(
    .H_START   (H_START),
    .H_END     (H_END),
    .V_START_P (V_START_P),
    .V_END_P   (V_END_P),
    .V_START_I (V_START_I),
    .V_END_I   (V_END_I),
    .RAM_WORDS (RAM_WORDS)
) u_checker (
    .clock        (clock),
    .nreset       (nreset),
    .counter_x    (counter_x),
    .counter_y    (counter_y),
    .line_doubler (line_doubler),
    .wren         (wren),
    .wraddr       (wraddr),
    .starttrigger (starttrigger)
);

//--- sim/video_capture_tb.sv
`timescale 1ns/100ps

module video_capture_tb;

    localparam int H_START      = 8;
    localparam int H_END        = 40;
    localparam int V_START_P    = 4;
    localparam int V_END_P      = 24;
    localparam int V_START_I    = 2;
    localparam int V_END_I      = 14;
    localparam int BUFFER_LINES = 4;
    localparam int TRIGGER_ADDR = 70;
    localparam int RAM_WORDS    = 512;

    localparam int CW           = video_pkg::COUNTER_WIDTH;
    localparam int AW           = video_pkg::ADDR_WIDTH;
    localparam int PW           = video_pkg::PIXEL_WIDTH;
    localparam int LINE_LEN     = H_END - H_START;
    localparam int FRAME_PIXELS = 64;
    localparam int FRAME_LINES  = 32;
    localparam int NUM_FRAMES   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = 20000;   // 8 x 2048 frame cycles, 2 x 512 readback, margin

    typedef struct packed {
        logic [AW-1:0] addr;
        logic [PW-1:0] data;
        logic          trigger;
        int            cycle;
    } write_entry_t;

    logic                   clock = 1'b0;
    logic                   nreset;
    logic [7:0]             red;
    logic [7:0]             green;
    logic [7:0]             blue;
    logic [CW-1:0]          counter_x;
    logic [CW-1:0]          counter_y;
    logic                   line_doubler;
    video_pkg::color_mode_t color_mode;
    video_pkg::gamma_mode_t gamma_mode;
    logic                   wren;
    logic [AW-1:0]          wraddr;
    logic [PW-1:0]          wrdata;
    logic                   starttrigger;
    logic [AW-1:0]          rd_addr;
    logic [PW-1:0]          rd_data;

    write_entry_t  expected_q[$];
    logic [PW-1:0] shadow_ram [RAM_WORDS];
    bit            shadow_valid [RAM_WORDS];
    int            model_base = 0;
    int            cycle_count = 0;
    int            writes_seen = 0;
    int            write_errors = 0;
    int            trigger_errors = 0;
    int            readback_errors = 0;
    int            count_errors = 0;

    video_capture_top #(
        .H_START (H_START), .H_END (H_END),
        .V_START_P (V_START_P), .V_END_P (V_END_P),
        .V_START_I (V_START_I), .V_END_I (V_END_I),
        .BUFFER_LINES (BUFFER_LINES), .TRIGGER_ADDR (TRIGGER_ADDR),
        .RAM_WORDS (RAM_WORDS)
    ) dut (.*);

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
    end

    // ====================
    // Reference model
    // ====================
    function automatic logic [PW-1:0] colour_model(input int r, input int g, input int b,
                                                   input video_pkg::color_mode_t mode);
        int grey;
        grey = (r + 2 * g + b) / 4;
        case (mode)
            video_pkg::COLOR_BGR:    return {8'(b), 8'(g), 8'(r)};
            video_pkg::COLOR_GREY:   return {8'(grey), 8'(grey), 8'(grey)};
            video_pkg::COLOR_INVERT: return {8'(255 - r), 8'(255 - g), 8'(255 - b)};
            default:                 return {8'(r), 8'(g), 8'(b)};
        endcase
    endfunction

    function automatic logic [7:0] gamma_model(input int x, input video_pkg::gamma_mode_t mode);
        case (mode)
            video_pkg::GAMMA_DARKEN:   return 8'(x * x / 256);
            video_pkg::GAMMA_BRIGHTEN: return 8'(255 - (255 - x) * (255 - x) / 256);
            default:                   return 8'(x);
        endcase
    endfunction

    task automatic model_pixel(input int x, input int y);
        int            v_start;
        int            v_end;
        int            addr;
        logic [PW-1:0] colour;
        write_entry_t  entry;
        v_start = line_doubler ? V_START_I : V_START_P;
        v_end   = line_doubler ? V_END_I : V_END_P;
        if (y >= v_start && y < v_end && x >= H_START && x < H_END) begin
            addr          = model_base + x - H_START;
            colour        = colour_model(int'(red), int'(green), int'(blue), color_mode);
            entry.addr    = AW'(addr);
            entry.data    = {gamma_model(int'(colour[23:16]), gamma_mode),
                             gamma_model(int'(colour[15:8]), gamma_mode),
                             gamma_model(int'(colour[7:0]), gamma_mode)};
            entry.trigger = (y - v_start < BUFFER_LINES) && (addr == TRIGGER_ADDR);
            entry.cycle   = cycle_count + 3;   // Capture, colour, gamma
            expected_q.push_back(entry);
            shadow_ram[addr]   = entry.data;
            shadow_valid[addr] = 1'b1;
        end
        if (x == H_END) begin
            if (y >= v_start && y < v_end && model_base < RAM_WORDS - LINE_LEN) begin
                model_base = model_base + LINE_LEN;
            end else begin
                model_base = 0;   // Wrap
            end
        end
    endtask

    // ====================
    // Compare tasks
    // ====================
    task automatic compare_write(input logic [AW-1:0] exp_addr, input logic [PW-1:0] exp_data,
                                 input int exp_cycle);
        if (wraddr !== exp_addr || wrdata !== exp_data || cycle_count != exp_cycle) begin
            $display("Error at %0t: write addr %0d data %06h cycle %0d, expected %0d %06h %0d",
                     $time, wraddr, wrdata, cycle_count, exp_addr, exp_data, exp_cycle);
            write_errors++;
        end
    endtask

    task automatic compare_trigger(input logic exp_trigger);
        if (starttrigger !== exp_trigger) begin
            $display("Error at %0t: starttrigger %b, expected %b",
                     $time, starttrigger, exp_trigger);
            trigger_errors++;
        end
    endtask

    task automatic compare_readback(input logic [AW-1:0] addr, input logic [PW-1:0] exp_data);
        if (rd_data !== exp_data) begin
            $display("Error at %0t: rd_data %06h at address %0d, expected %06h",
                     $time, rd_data, addr, exp_data);
            readback_errors++;
        end
    endtask

    task automatic compare_line_count(input int frame, input int exp_lines, input int writes);
        if (writes != exp_lines * LINE_LEN) begin
            $display("Error at %0t: frame %0d wrote %0d pixels, expected %0d lines",
                     $time, frame, writes, exp_lines);
            count_errors++;
        end
    endtask

    always @(negedge clock) begin : write_monitor
        write_entry_t entry;
        if (nreset === 1'b1) begin
            if (wren) begin
                writes_seen++;
                if (expected_q.size() == 0) begin
                    $display("Write to address %0d at %0t has no captured pixel behind it",
                             wraddr, $time);
                    write_errors++;
                end else begin
                    entry = expected_q.pop_front();
                    compare_write(entry.addr, entry.data, entry.cycle);
                    compare_trigger(entry.trigger);
                end
            end else begin
                compare_trigger(1'b0);
            end
        end
    end

    // ====================
    // Stimulus
    // ====================
    task automatic drive_pixel(input int x, input int y);
        @(posedge clock);
        #1;
        counter_x = CW'(x);
        counter_y = CW'(y);
        red       = 8'($urandom);
        green     = 8'($urandom);
        blue      = 8'($urandom);
        model_pixel(x, y);
    endtask

    task automatic run_frame(input int frame);
        int x;
        int y;
        int lines;
        int writes_before;
        // First two frames cover both windows
        line_doubler = (frame < 2) ? 1'(frame) : 1'($urandom);
        color_mode   = video_pkg::color_mode_t'(2'($urandom));
        gamma_mode   = video_pkg::gamma_mode_t'(2'($urandom));
        $display("Frame %0d: line_doubler %0b, %s, %s",
                 frame, line_doubler, color_mode.name(), gamma_mode.name());
        lines         = line_doubler ? V_END_I - V_START_I : V_END_P - V_START_P;
        writes_before = writes_seen;
        for (y = 0; y < FRAME_LINES; y++) begin
            for (x = 0; x < FRAME_PIXELS; x++) begin
                drive_pixel(x, y);
            end
        end
        compare_line_count(frame, lines, writes_seen - writes_before);
    endtask

    task automatic readback_all();
        int a;
        for (a = 0; a < RAM_WORDS; a++) begin
            @(posedge clock);
            #1;
            rd_addr = AW'(a);
            @(posedge clock);
            @(negedge clock);
            if (shadow_valid[a]) begin
                compare_readback(AW'(a), shadow_ram[a]);
            end
        end
    endtask

    task automatic end_run(input bit timed_out);
        int total;
        total = write_errors + trigger_errors + readback_errors + count_errors
              + dut.u_checker.assert_failures;
        $display("Errors: write %0d, trigger %0d, readback %0d, line count %0d, assertion %0d",
                 write_errors, trigger_errors, readback_errors, count_errors,
                 dut.u_checker.assert_failures);
        if (!timed_out && total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin : main
        int frame;
        void'($urandom(32'hfe537000));
        nreset       = 1'b0;
        red          = '0;
        green        = '0;
        blue         = '0;
        counter_x    = '0;
        counter_y    = '0;
        line_doubler = 1'b0;
        color_mode   = video_pkg::COLOR_RGB;
        gamma_mode   = video_pkg::GAMMA_LINEAR;
        rd_addr      = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        nreset = 1'b1;
        for (frame = 0; frame < NUM_FRAMES; frame++) begin
            run_frame(frame);
        end
        readback_all();
        if (expected_q.size() != 0) begin
            $display("%0d expected writes never appeared", expected_q.size());
            write_errors += expected_q.size();
        end
        end_run(1'b0);
    end

    initial begin : watchdog
        wait (cycle_count >= MAX_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        end_run(1'b1);
    end

endmodule

//--- src.f
hw/video_pkg.sv
hw/video2ram.sv
hw/color_conv.sv
hw/gamma_conv.sv
hw/frame_buffer_ram.sv
hw/video_capture_top.sv
sim/video_capture_checker.sv
sim/video_capture_tb.sv
